// File: source/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

//////////////////////////////////////////////////
// Channel count
//////////////////////////////////////////////////

// Number of serial channels behind the bus
`define UART_NUM_CHANNELS 4
// Width of the channel field, in step with the count
`define UART_CHAN_BITS 2

//////////////////////////////////////////////////
// Divider and address map
//////////////////////////////////////////////////

// Clocks per bit after reset
`define UART_DEFAULT_DIV 16
// Register field, two bits from here
`define UART_REG_LSB 2
// Channel field starts above the register field
`define UART_CHAN_LSB 4

`endif

// File: source/uart_pkg.sv
package uart_pkg;

   // Register selector, taken from the address
   typedef enum logic [1:0] {
      REG_DIV  = 2'd0,
      REG_DATA = 2'd1,
      REG_STAT = 2'd2
   } reg_sel_e;

   // Transmit FSM
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

   // Receive FSM
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   // Broadcast from the bus slave to every channel
   typedef struct packed {
      logic        wr;
      logic        rd;
      reg_sel_e    sel;
      logic [31:0] wdata;
   } uart_cmd_t;

   // Per-channel status back to the read path
   typedef struct packed {
      logic [15:0] div;
      logic [7:0]  rx_data;
      logic        rx_valid;
      logic        tx_busy;
   } uart_stat_t;

endpackage

// File: source/uart_axil_slave.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_axil_slave (
   input  logic                             clk,
   input  logic                             uart_resetn,
   input  logic                             awvalid,
   input  logic [31:0]                      awaddr,
   input  logic                             wvalid,
   input  logic [31:0]                      wdata,
   input  logic                             bready,
   input  logic                             arvalid,
   input  logic [31:0]                      araddr,
   input  logic [`UART_NUM_CHANNELS-1:0]    tx_busy,
   input  logic                             rd_busy,
   output logic                             awready,
   output logic                             wready,
   output logic                             bvalid,
   output logic                             arready,
   output uart_pkg::uart_cmd_t              cmd,
   output logic [`UART_NUM_CHANNELS-1:0]    chan_sel,
   output logic [`UART_CHAN_BITS-1:0]       rd_chan
);

   logic                        wr_ack;
   logic                        wr_go;
   logic                        rd_go;
   logic                        wr_stb;
   logic                        rd_stb;
   logic [`UART_CHAN_BITS-1:0]  aw_chan;
   logic [`UART_CHAN_BITS-1:0]  ar_chan;
   uart_pkg::reg_sel_e          aw_sel;
   uart_pkg::reg_sel_e          ar_sel;
   logic [`UART_CHAN_BITS-1:0]  chan_q;
   uart_pkg::reg_sel_e          sel_q;
   logic [31:0]                 wdata_q;

   // Address fields
   assign aw_chan = awaddr[`UART_CHAN_LSB +: `UART_CHAN_BITS];
   assign ar_chan = araddr[`UART_CHAN_LSB +: `UART_CHAN_BITS];
   assign aw_sel  = uart_pkg::reg_sel_e'(awaddr[`UART_REG_LSB +: 2]);
   assign ar_sel  = uart_pkg::reg_sel_e'(araddr[`UART_REG_LSB +: 2]);

   // Take address and data together; hold off data writes to a busy transmitter
   assign wr_go = awvalid && wvalid && !bvalid && !wr_ack &&
                  !((aw_sel == uart_pkg::REG_DATA) && tx_busy[aw_chan]);
   // Reads yield to a write deciding in the same cycle
   assign rd_go = arvalid && !arready && !rd_busy && !wr_go;

   //////////////////////////////////////////////////
   // Handshakes and strobes
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge uart_resetn) begin
      if (!uart_resetn) begin
         wr_ack  <= 1'b0;
         arready <= 1'b0;
         wr_stb  <= 1'b0;
         rd_stb  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         wr_ack  <= wr_go;
         arready <= rd_go;
         // One-cycle command after each handshake
         wr_stb  <= wr_ack;
         rd_stb  <= arready;
         if (wr_ack) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // Payload captured in the handshake cycle
   always_ff @(posedge clk) begin
      if (wr_ack) begin
         chan_q  <= aw_chan;
         sel_q   <= aw_sel;
         wdata_q <= wdata;
      end else if (arready) begin
         chan_q <= ar_chan;
         sel_q  <= ar_sel;
      end
   end

   assign awready = wr_ack;
   assign wready  = wr_ack;

   // Command broadcast, one-hot select only while a strobe is up
   assign cmd      = '{wr: wr_stb, rd: rd_stb, sel: sel_q, wdata: wdata_q};
   assign chan_sel = (wr_stb || rd_stb) ?
                     ({{(`UART_NUM_CHANNELS-1){1'b0}}, 1'b1} << chan_q) : '0;
   assign rd_chan  = chan_q;

   // Write response held until taken
   a_bvalid_hold: assert property (@(posedge clk) disable iff (!uart_resetn)
      bvalid && !bready |=> bvalid);

endmodule

// File: source/uart_channel.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_channel (
   input  logic                 clk,
   input  logic                 uart_resetn,
   input  uart_pkg::uart_cmd_t  cmd,
   input  logic                 chan_en,
   input  logic                 ser_rx,
   output logic                 ser_tx,
   output uart_pkg::uart_stat_t stat
);

   logic [15:0]         div_q;
   logic                wr_div;
   logic                wr_data;
   logic                rd_data;
   uart_pkg::tx_state_e tx_state;
   logic [15:0]         tx_cnt;
   logic [2:0]          tx_bit;
   logic [7:0]          tx_byte;
   logic                tx_bit_end;
   uart_pkg::rx_state_e rx_state;
   logic [1:0]          rx_sync;
   logic                rx_in;
   logic [15:0]         rx_cnt;
   logic [2:0]          rx_bit;
   logic [7:0]          rx_shift;
   logic [7:0]          rx_hold;
   logic                rx_valid;
   logic                rx_bit_end;
   logic                rx_mid;

   // Commands for this channel only
   assign wr_div  = chan_en && cmd.wr && (cmd.sel == uart_pkg::REG_DIV);
   assign wr_data = chan_en && cmd.wr && (cmd.sel == uart_pkg::REG_DATA);
   assign rd_data = chan_en && cmd.rd && (cmd.sel == uart_pkg::REG_DATA);

   // Clocks per bit
   always_ff @(posedge clk or negedge uart_resetn) begin
      if (!uart_resetn) begin
         div_q <= 16'(`UART_DEFAULT_DIV);
      end else if (wr_div) begin
         div_q <= cmd.wdata[15:0];
      end
   end

   //////////////////////////////////////////////////
   // Transmitter
   //////////////////////////////////////////////////
   assign tx_bit_end = (tx_cnt == div_q - 16'd1);

   always_ff @(posedge clk) begin
      if (wr_data) begin
         tx_byte <= cmd.wdata[7:0];
      end
   end

   always_ff @(posedge clk or negedge uart_resetn) begin
      if (!uart_resetn) begin
         tx_state <= uart_pkg::TX_IDLE;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         ser_tx   <= 1'b1;
      end else begin
         tx_cnt <= tx_bit_end ? 16'd0 : tx_cnt + 16'd1;
         case (tx_state)
            uart_pkg::TX_IDLE: begin
               tx_cnt <= '0;
               if (wr_data) begin
                  tx_state <= uart_pkg::TX_START;
                  ser_tx   <= 1'b0;
               end
            end
            uart_pkg::TX_START: begin
               if (tx_bit_end) begin
                  tx_state <= uart_pkg::TX_DATA;
                  tx_bit   <= '0;
                  ser_tx   <= tx_byte[0];
               end
            end
            uart_pkg::TX_DATA: begin
               // LSB first, stop bit after bit 7
               if (tx_bit_end) begin
                  if (tx_bit == 3'd7) begin
                     tx_state <= uart_pkg::TX_STOP;
                     ser_tx   <= 1'b1;
                  end else begin
                     tx_bit <= tx_bit + 3'd1;
                     ser_tx <= tx_byte[tx_bit + 3'd1];
                  end
               end
            end
            default: begin
               if (tx_bit_end) begin
                  tx_state <= uart_pkg::TX_IDLE;
               end
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Receiver
   //////////////////////////////////////////////////
   assign rx_in      = rx_sync[1];
   assign rx_mid     = (rx_cnt == {1'b0, div_q[15:1]});
   assign rx_bit_end = (rx_cnt == div_q - 16'd1);

   always_ff @(posedge clk or negedge uart_resetn) begin
      if (!uart_resetn) begin
         rx_sync  <= 2'b11;
         rx_state <= uart_pkg::RX_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], ser_rx};
         rx_cnt  <= rx_cnt + 16'd1;
         // Read of the data register empties the holding byte
         if (rd_data) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            uart_pkg::RX_IDLE: begin
               rx_cnt <= '0;
               if (!rx_in) begin
                  rx_state <= uart_pkg::RX_START;
               end
            end
            uart_pkg::RX_START: begin
               // Start bit must still be low at mid-bit
               if (rx_mid) begin
                  rx_cnt   <= '0;
                  rx_bit   <= '0;
                  rx_state <= rx_in ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
               end
            end
            uart_pkg::RX_DATA: begin
               if (rx_bit_end) begin
                  rx_cnt <= '0;
                  rx_bit <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= uart_pkg::RX_STOP;
                  end
               end
            end
            default: begin
               if (rx_bit_end) begin
                  rx_state <= uart_pkg::RX_IDLE;
                  // New byte wins over a clear in the same cycle
                  if (rx_in) begin
                     rx_valid <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // Shift in at mid-bit, hold on a good stop bit
   always_ff @(posedge clk) begin
      if ((rx_state == uart_pkg::RX_DATA) && rx_bit_end) begin
         rx_shift <= {rx_in, rx_shift[7:1]};
      end
      if ((rx_state == uart_pkg::RX_STOP) && rx_bit_end && rx_in) begin
         rx_hold <= rx_shift;
      end
   end

   assign stat = '{div: div_q, rx_data: rx_hold, rx_valid: rx_valid,
                   tx_busy: (tx_state != uart_pkg::TX_IDLE)};

   // Bus back-pressure keeps data writes away from a busy transmitter
   a_no_write_busy: assert property (@(posedge clk) disable iff (!uart_resetn)
      wr_data |-> (tx_state == uart_pkg::TX_IDLE));
   // Divider below 2 breaks mid-bit sampling
   a_div_min: assert property (@(posedge clk) disable iff (!uart_resetn)
      wr_div |-> (cmd.wdata[15:0] >= 16'd2));

endmodule

// File: source/uart_read_collect.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_read_collect (
   input  logic                                          clk,
   input  logic                                          uart_resetn,
   input  uart_pkg::uart_cmd_t                           cmd,
   input  logic [`UART_CHAN_BITS-1:0]                    rd_chan,
   input  uart_pkg::uart_stat_t [`UART_NUM_CHANNELS-1:0] stat_all,
   input  logic                                          rready,
   output logic [31:0]                                   rdata,
   output logic                                          rvalid,
   output logic                                          rd_busy
);

   uart_pkg::uart_stat_t sel_stat;
   logic [31:0]          rd_word;

   assign sel_stat = stat_all[rd_chan];

   // Read word by register
   always_comb begin
      case (cmd.sel)
         uart_pkg::REG_DIV:  rd_word = {16'd0, sel_stat.div};
         // All ones when nothing is held
         uart_pkg::REG_DATA: rd_word = sel_stat.rx_valid ? {24'd0, sel_stat.rx_data} : 32'hFFFF_FFFF;
         uart_pkg::REG_STAT: rd_word = {30'd0, sel_stat.rx_valid, sel_stat.tx_busy};
         default:            rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (cmd.rd) begin
         rdata <= rd_word;
      end
   end

   always_ff @(posedge clk or negedge uart_resetn) begin
      if (!uart_resetn) begin
         rvalid <= 1'b0;
      end else if (cmd.rd) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   // Busy from the read strobe until the response is taken
   assign rd_busy = rvalid || cmd.rd;

   a_rdata_stable: assert property (@(posedge clk) disable iff (!uart_resetn)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: source/iob_axi_multiuart.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module iob_axi_multiuart (
   input  logic                          clk,
   input  logic                          uart_resetn,
   // Write address and data
   input  logic                          uart_axi_awvalid,
   output logic                          uart_axi_awready,
   input  logic [31:0]                   uart_axi_awaddr,
   input  logic                          uart_axi_wvalid,
   output logic                          uart_axi_wready,
   input  logic [31:0]                   uart_axi_wdata,
   // Write response
   output logic                          uart_axi_bvalid,
   input  logic                          uart_axi_bready,
   // Read address and data
   input  logic                          uart_axi_arvalid,
   output logic                          uart_axi_arready,
   input  logic [31:0]                   uart_axi_araddr,
   output logic                          uart_axi_rvalid,
   input  logic                          uart_axi_rready,
   output logic [31:0]                   uart_axi_rdata,
   // Serial lines
   input  logic [`UART_NUM_CHANNELS-1:0] ser_rx,
   output logic [`UART_NUM_CHANNELS-1:0] ser_tx
);

   uart_pkg::uart_cmd_t                           cmd;
   uart_pkg::uart_stat_t [`UART_NUM_CHANNELS-1:0] stat_all;
   logic [`UART_NUM_CHANNELS-1:0]                 chan_sel;
   logic [`UART_NUM_CHANNELS-1:0]                 tx_busy;
   logic [`UART_CHAN_BITS-1:0]                    rd_chan;
   logic                                          rd_busy;

   //////////////////////////////////////////////////
   // Bus front end
   //////////////////////////////////////////////////
   uart_axil_slave u_slave (
      .clk         (clk),
      .uart_resetn (uart_resetn),
      .awvalid     (uart_axi_awvalid),
      .awaddr      (uart_axi_awaddr),
      .wvalid      (uart_axi_wvalid),
      .wdata       (uart_axi_wdata),
      .bready      (uart_axi_bready),
      .arvalid     (uart_axi_arvalid),
      .araddr      (uart_axi_araddr),
      .tx_busy     (tx_busy),
      .rd_busy     (rd_busy),
      .awready     (uart_axi_awready),
      .wready      (uart_axi_wready),
      .bvalid      (uart_axi_bvalid),
      .arready     (uart_axi_arready),
      .cmd         (cmd),
      .chan_sel    (chan_sel),
      .rd_chan     (rd_chan)
   );

   // Identical channels sharing the command
   for (genvar i = 0; i < `UART_NUM_CHANNELS; i++) begin : g_chan
      uart_channel u_chan (
         .clk         (clk),
         .uart_resetn (uart_resetn),
         .cmd         (cmd),
         .chan_en     (chan_sel[i]),
         .ser_rx      (ser_rx[i]),
         .ser_tx      (ser_tx[i]),
         .stat        (stat_all[i])
      );
      assign tx_busy[i] = stat_all[i].tx_busy;
   end

   // Read data path
   uart_read_collect u_collect (
      .clk         (clk),
      .uart_resetn (uart_resetn),
      .cmd         (cmd),
      .rd_chan     (rd_chan),
      .stat_all    (stat_all),
      .rready      (uart_axi_rready),
      .rdata       (uart_axi_rdata),
      .rvalid      (uart_axi_rvalid),
      .rd_busy     (rd_busy)
   );

endmodule

// File: verification/uart_tb_clock.sv
`timescale 1ns/10ps

module uart_tb_clock (
   output logic clk
);

   // 4 ns period, starts low
   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

endmodule

// File: verification/uart_tb.sv
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_tb;

   //////////////////////////////////////////////////
   // Run length limit
   //////////////////////////////////////////////////
   localparam int MAX_DIV       = 20;
   // One frame plus receiver latency
   localparam int BYTE_CYCLES   = 10 * MAX_DIV + 20;
   localparam int N_LOOP        = 4;
   localparam int N_DIV         = 8;
   // Loopback bytes, two back-pressure bytes, one stalled byte, one parallel frame
   localparam int SERIAL_BYTES  = N_LOOP + 2 + 1 + 1;
   // Worst bus access with the longest stall
   localparam int ACCESS_CYCLES = 40;
   localparam int N_ACCESS      = 150;
   localparam int TIMEOUT_CYCLES = SERIAL_BYTES * BYTE_CYCLES + N_ACCESS * ACCESS_CYCLES + 500;

   logic                          clk;
   logic                          uart_resetn;
   logic                          awvalid;
   logic                          awready;
   logic [31:0]                   awaddr;
   logic                          wvalid;
   logic                          wready;
   logic [31:0]                   wdata;
   logic                          bvalid;
   logic                          bready;
   logic                          arvalid;
   logic                          arready;
   logic [31:0]                   araddr;
   logic                          rvalid;
   logic                          rready;
   logic [31:0]                   rdata;
   logic [`UART_NUM_CHANNELS-1:0] ser;

   logic [31:0] lfsr = 32'h48bf_b68c;
   logic [31:0] model_div [`UART_NUM_CHANNELS];
   logic [7:0]  model_byte [`UART_NUM_CHANNELS];
   int          cycle_count = 0;
   int          last_aw_cycle = 0;
   int          errors = 0;
   int          failed_tests = 0;

   uart_tb_clock u_clock (
      .clk (clk)
   );

   // Each ser_tx loops back to its own ser_rx
   iob_axi_multiuart dut (
      .clk              (clk),
      .uart_resetn      (uart_resetn),
      .uart_axi_awvalid (awvalid),
      .uart_axi_awready (awready),
      .uart_axi_awaddr  (awaddr),
      .uart_axi_wvalid  (wvalid),
      .uart_axi_wready  (wready),
      .uart_axi_wdata   (wdata),
      .uart_axi_bvalid  (bvalid),
      .uart_axi_bready  (bready),
      .uart_axi_arvalid (arvalid),
      .uart_axi_arready (arready),
      .uart_axi_araddr  (araddr),
      .uart_axi_rvalid  (rvalid),
      .uart_axi_rready  (rready),
      .uart_axi_rdata   (rdata),
      .ser_rx           (ser),
      .ser_tx           (ser)
   );

   // Hang guard
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, a handshake or byte never completed", cycle_count);
         $display("tests failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Random numbers
   //////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] val;
      int          k;
      val = '0;
      for (k = 0; k < nbits; k++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   // Divider in 2..20
   function automatic logic [31:0] rand_div();
      return 32'd2 + (rand_bits(5) % 32'd19);
   endfunction

   function automatic logic [31:0] reg_addr(input int chan, input uart_pkg::reg_sel_e sel);
      return (32'(chan) << `UART_CHAN_LSB) | (32'(sel) << `UART_REG_LSB);
   endfunction

   // Idle transmitter, flags as given
   function automatic uart_pkg::uart_stat_t expect_stat(input int chan, input logic rxv);
      return '{div: model_div[chan][15:0], rx_data: 8'd0, rx_valid: rxv, tx_busy: 1'b0};
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // rx_data travels through REG_DATA reads, not compared here
   task automatic check_stat(input string name, input uart_pkg::uart_stat_t got,
                             input uart_pkg::uart_stat_t exp);
      if (got.div !== exp.div || got.rx_valid !== exp.rx_valid ||
          got.tx_busy !== exp.tx_busy) begin
         $display("FAIL %s: got div=%h rx_valid=%h tx_busy=%h expected div=%h rx_valid=%h tx_busy=%h",
                  name, got.div, got.rx_valid, got.tx_busy, exp.div, exp.rx_valid, exp.tx_busy);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Bus access
   //////////////////////////////////////////////////
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input int stall);
      int i;
      @(posedge clk);
      awvalid <= 1'b1;
      awaddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      // Ready seen at negedge means handshake on the next edge
      do @(negedge clk); while (!(awready && wready));
      @(posedge clk);
      last_aw_cycle = cycle_count;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(negedge clk); while (!bvalid);
      for (i = 0; i < stall; i++) begin
         @(posedge clk);
         @(negedge clk);
         if (!bvalid) begin
            $display("bvalid dropped while bready was held low");
            errors++;
         end
      end
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] addr, input int stall, output logic [31:0] data);
      logic [31:0] first;
      int          i;
      @(posedge clk);
      arvalid <= 1'b1;
      araddr  <= addr;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      do @(negedge clk); while (!rvalid);
      first = rdata;
      for (i = 0; i < stall; i++) begin
         @(posedge clk);
         @(negedge clk);
         if (!rvalid) begin
            $display("rvalid dropped while rready was held low");
            errors++;
         end
         check_word("rdata during stall", rdata, first);
      end
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
      data = first;
   endtask

   task automatic read_stat(input int chan, output uart_pkg::uart_stat_t s);
      logic [31:0] w_div;
      logic [31:0] w_stat;
      bus_read(reg_addr(chan, uart_pkg::REG_DIV), int'(rand_bits(2)), w_div);
      bus_read(reg_addr(chan, uart_pkg::REG_STAT), int'(rand_bits(2)), w_stat);
      check_word($sformatf("ch%0d stat upper bits", chan), w_stat & 32'hFFFF_FFFC, 32'd0);
      s = '{div: w_div[15:0], rx_data: 8'd0, rx_valid: w_stat[1], tx_busy: w_stat[0]};
   endtask

   // Poll until a byte is held and the transmitter is idle
   task automatic wait_rx_idle(input int chan);
      logic [31:0] w;
      do bus_read(reg_addr(chan, uart_pkg::REG_STAT), int'(rand_bits(2)), w);
      while (w[1:0] != 2'b10);
   endtask

   task automatic end_test(input int num, input string name, input int err_start);
      if (errors == err_start) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errors - err_start);
         failed_tests++;
      end
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////
   task automatic test_reset();
      uart_pkg::uart_stat_t s;
      logic [31:0]          w;
      int                   c;
      for (c = 0; c < `UART_NUM_CHANNELS; c++) begin
         read_stat(c, s);
         check_stat($sformatf("ch%0d reset stat", c), s, expect_stat(c, 1'b0));
         bus_read(reg_addr(c, uart_pkg::REG_DATA), int'(rand_bits(2)), w);
         check_word($sformatf("ch%0d reset data", c), w, 32'hFFFF_FFFF);
      end
   endtask

   task automatic test_div_write();
      logic [31:0] w;
      int          n;
      int          c;
      int          chan;
      for (n = 0; n < N_DIV; n++) begin
         chan = int'(rand_bits(`UART_CHAN_BITS));
         model_div[chan] = rand_div();
         bus_write(reg_addr(chan, uart_pkg::REG_DIV), model_div[chan], int'(rand_bits(2)));
         // Other channels keep their dividers
         for (c = 0; c < `UART_NUM_CHANNELS; c++) begin
            bus_read(reg_addr(c, uart_pkg::REG_DIV), int'(rand_bits(2)), w);
            check_word($sformatf("ch%0d div", c), w, model_div[c]);
         end
      end
   endtask

   task automatic test_loopback();
      uart_pkg::uart_stat_t s;
      logic [31:0]          w;
      int                   n;
      int                   chan;
      for (n = 0; n < N_LOOP; n++) begin
         chan = int'(rand_bits(`UART_CHAN_BITS));
         model_byte[chan] = 8'(rand_bits(8));
         bus_write(reg_addr(chan, uart_pkg::REG_DATA), {24'd0, model_byte[chan]},
                   int'(rand_bits(2)));
         wait_rx_idle(chan);
         bus_read(reg_addr(chan, uart_pkg::REG_DATA), int'(rand_bits(2)), w);
         check_word($sformatf("ch%0d rx data", chan), w, {24'd0, model_byte[chan]});
         // Data read empties the holding register
         read_stat(chan, s);
         check_stat($sformatf("ch%0d after read", chan), s, expect_stat(chan, 1'b0));
      end
   endtask

   task automatic test_backpressure();
      logic [31:0] w;
      logic [7:0]  first_byte;
      int          chan;
      int          first_cycle;
      chan = int'(rand_bits(`UART_CHAN_BITS));
      // Divider of 8 or more, so the last byte lands before tx goes idle
      model_div[chan] = 32'd8 + (rand_bits(4) % 32'd13);
      bus_write(reg_addr(chan, uart_pkg::REG_DIV), model_div[chan], int'(rand_bits(2)));
      first_byte = 8'(rand_bits(8));
      model_byte[chan] = 8'(rand_bits(8));
      bus_write(reg_addr(chan, uart_pkg::REG_DATA), {24'd0, first_byte}, int'(rand_bits(2)));
      first_cycle = last_aw_cycle;
      bus_write(reg_addr(chan, uart_pkg::REG_DATA), {24'd0, model_byte[chan]},
                int'(rand_bits(2)));
      if (last_aw_cycle - first_cycle < 10 * int'(model_div[chan])) begin
         $display("second data write accepted %0d cycles after the first, transmitter still busy",
                  last_aw_cycle - first_cycle);
         errors++;
      end
      // Second byte overwrites the first
      wait_rx_idle(chan);
      bus_read(reg_addr(chan, uart_pkg::REG_DATA), int'(rand_bits(2)), w);
      check_word($sformatf("ch%0d second byte", chan), w, {24'd0, model_byte[chan]});
   endtask

   task automatic test_stalls();
      logic [31:0] w;
      int          c;
      int          chan;
      chan = int'(rand_bits(`UART_CHAN_BITS));
      model_div[chan] = rand_div();
      bus_write(reg_addr(chan, uart_pkg::REG_DIV), model_div[chan], 8 + int'(rand_bits(3)));
      for (c = 0; c < `UART_NUM_CHANNELS; c++) begin
         bus_read(reg_addr(c, uart_pkg::REG_DIV), 8 + int'(rand_bits(3)), w);
         check_word($sformatf("ch%0d div after stall", c), w, model_div[c]);
      end
      // Stalled data write sends one byte only
      model_byte[chan] = 8'(rand_bits(8));
      bus_write(reg_addr(chan, uart_pkg::REG_DATA), {24'd0, model_byte[chan]},
                8 + int'(rand_bits(3)));
      wait_rx_idle(chan);
      // Stalled read of the held byte clears it exactly once
      bus_read(reg_addr(chan, uart_pkg::REG_DATA), 8 + int'(rand_bits(3)), w);
      check_word($sformatf("ch%0d stalled data", chan), w, {24'd0, model_byte[chan]});
      bus_read(reg_addr(chan, uart_pkg::REG_STAT), 8 + int'(rand_bits(3)), w);
      check_word($sformatf("ch%0d stalled stat", chan), w, 32'd0);
      bus_read(reg_addr(chan, uart_pkg::REG_DATA), 8 + int'(rand_bits(3)), w);
      check_word($sformatf("ch%0d data after clear", chan), w, 32'hFFFF_FFFF);
   endtask

   task automatic test_independence();
      logic [31:0] w;
      int          c;
      // Distinct dividers, 5..20
      for (c = 0; c < `UART_NUM_CHANNELS; c++) begin
         model_div[c] = 32'd5 + ((32'(4 * c) + rand_bits(2)) % 32'd16);
         bus_write(reg_addr(c, uart_pkg::REG_DIV), model_div[c], int'(rand_bits(2)));
      end
      // Channel number in the top bits keeps the bytes apart
      for (c = 0; c < `UART_NUM_CHANNELS; c++) begin
         model_byte[c] = {c[1:0], 6'(rand_bits(6))};
         bus_write(reg_addr(c, uart_pkg::REG_DATA), {24'd0, model_byte[c]}, int'(rand_bits(2)));
      end
      for (c = 0; c < `UART_NUM_CHANNELS; c++) begin
         wait_rx_idle(c);
         bus_read(reg_addr(c, uart_pkg::REG_DATA), int'(rand_bits(2)), w);
         check_word($sformatf("ch%0d own byte", c), w, {24'd0, model_byte[c]});
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      int err_start;
      uart_resetn = 1'b0;
      awvalid     = 1'b0;
      awaddr      = '0;
      wvalid      = 1'b0;
      wdata       = '0;
      bready      = 1'b0;
      arvalid     = 1'b0;
      araddr      = '0;
      rready      = 1'b0;
      for (int c = 0; c < `UART_NUM_CHANNELS; c++) begin
         model_div[c]  = `UART_DEFAULT_DIV;
         model_byte[c] = 8'd0;
      end
      // Reset held for two cycles
      repeat (2) @(posedge clk);
      uart_resetn <= 1'b1;

      err_start = errors;
      test_reset();
      end_test(1, "reset state", err_start);
      err_start = errors;
      test_div_write();
      end_test(2, "divider writes", err_start);
      err_start = errors;
      test_loopback();
      end_test(3, "loopback", err_start);
      err_start = errors;
      test_backpressure();
      end_test(4, "write back-pressure", err_start);
      err_start = errors;
      test_stalls();
      end_test(5, "response stalls", err_start);
      err_start = errors;
      test_independence();
      end_test(6, "channel independence", err_start);

      $display("%0d tests run, %0d ok, %0d with errors, %0d check errors", 6,
               6 - failed_tests, failed_tests, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: iob_axi_multiuart.f
+incdir+source
source/uart_pkg.sv
source/uart_axil_slave.sv
source/uart_channel.sv
source/uart_read_collect.sv
source/iob_axi_multiuart.sv
verification/uart_tb_clock.sv
verification/uart_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP       := uart_tb
FILELIST  := iob_axi_multiuart.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := all tests passed

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message shows up on a line of its own
run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
